/* hdl/div_types_pkg.sv */
// operand, cycle count and controller state types, imported by the divider RTL modules
package div_types_pkg;

	// widest operand the bus can carry
	localparam int op_max_bits = 32;

	// busy-cycle counter width
	localparam int cycles_bits = 32;

	// one operand, quotient or remainder word
	// modules only use the low op_bits bits
	typedef logic [op_max_bits-1:0] op_t;

	// busy-cycle count, saturates at all ones
	typedef logic [cycles_bits-1:0] cycles_t;

	// controller states
	typedef enum logic [2:0] {
		// waiting for start
		st_idle,
		// remainder := dividend, zero divisor test
		st_load,
		// can the divisor still be subtracted
		st_check,
		// one subtraction, quotient + 1
		st_sub,
		// result valid until next start
		st_done
	} div_state_t;

endpackage

/* hdl/div_regmap_pkg.sv */
// AXI4-Lite register map, bus widths and response codes for the divider peripheral
package div_regmap_pkg;

	// bus geometry
	localparam int axil_addr_bits = 8;
	localparam int axil_data_bits = 32;
	localparam int axil_strb_bits = axil_data_bits / 8;

	typedef logic [axil_addr_bits-1:0] axil_addr_t;
	typedef logic [axil_data_bits-1:0] axil_data_t;
	typedef logic [1:0] axil_resp_t;

	// response codes
	localparam axil_resp_t resp_okay   = 2'b00;
	localparam axil_resp_t resp_slverr = 2'b10;

	// byte offsets
	localparam axil_addr_t reg_dividend = 8'h00;
	localparam axil_addr_t reg_divisor  = 8'h04;
	localparam axil_addr_t reg_ctrl     = 8'h08;
	localparam axil_addr_t reg_status   = 8'h0C;
	localparam axil_addr_t reg_quot     = 8'h10;
	localparam axil_addr_t reg_rem      = 8'h14;
	localparam axil_addr_t reg_cycles   = 8'h18;

	// reg_ctrl bits
	localparam int ctrl_start_bit = 0;

	// reg_status bits
	localparam int status_busy_bit = 0;
	localparam int status_done_bit = 1;
	localparam int status_zero_bit = 2;

endpackage

/* hdl/div_step_if.sv */
// step bus between the divider controller and the datapath, one modport per side
interface div_step_if;
	import div_types_pkg::*;

	// controller -> datapath
	// remainder := dividend, quotient := 0
	logic load;
	// one subtraction, quotient + 1
	logic step;
	// zero divisor, force quotient to all ones
	logic zero_fix;

	// datapath -> controller
	// remainder >= divisor
	logic ge;
	// divisor is zero
	logic is_zero_div;

	// results, read by the register block through the top level
	op_t quotient;
	op_t remainder;

	modport ctrl (
		output load, step, zero_fix,
		input  ge, is_zero_div
	);

	modport data (
		input  load, step, zero_fix,
		output ge, is_zero_div, quotient, remainder
	);

endinterface

/* hdl/div_axil_regs.sv */
// AXI4-Lite slave of the divider, holds the operands, decodes the register map, pulses start
module div_axil_regs #(
	parameter int op_bits = 16
) (
	input  logic in_clk,
	input  logic in_rst,

	// AXI4-Lite slave
	input  div_regmap_pkg::axil_addr_t s_axil_awaddr,
	input  logic s_axil_awvalid,
	output logic s_axil_awready,
	input  div_regmap_pkg::axil_data_t s_axil_wdata,
	input  logic [div_regmap_pkg::axil_strb_bits-1:0] s_axil_wstrb,
	input  logic s_axil_wvalid,
	output logic s_axil_wready,
	output div_regmap_pkg::axil_resp_t s_axil_bresp,
	output logic s_axil_bvalid,
	input  logic s_axil_bready,
	input  div_regmap_pkg::axil_addr_t s_axil_araddr,
	input  logic s_axil_arvalid,
	output logic s_axil_arready,
	output div_regmap_pkg::axil_data_t s_axil_rdata,
	output div_regmap_pkg::axil_resp_t s_axil_rresp,
	output logic s_axil_rvalid,
	input  logic s_axil_rready,

	// controller side
	output logic start,
	input  logic busy,
	input  logic done,
	input  logic div_zero,

	// results and operands
	input  div_types_pkg::op_t quotient,
	input  div_types_pkg::op_t remainder,
	input  div_types_pkg::cycles_t cycles,
	output div_types_pkg::op_t dividend,
	output div_types_pkg::op_t divisor
);
	import div_types_pkg::*;
	import div_regmap_pkg::*;

	// operand bits above op_bits stay zero
	localparam op_t op_mask = op_t'((64'd1 << op_bits) - 64'd1);

	typedef enum logic [1:0] {wr_idle, wr_accept, wr_resp} wr_state_t;
	typedef enum logic [1:0] {rd_idle, rd_accept, rd_resp} rd_state_t;

	wr_state_t wr_state;
	rd_state_t rd_state;

	logic wr_hs, wr_en, wr_err;
	logic wr_dividend, wr_divisor, wr_start;
	logic start_arm;
	logic rd_hs, rd_err;
	axil_data_t rd_data;

	// ready and valid come straight from the channel states
	assign s_axil_awready = (wr_state == wr_accept);
	assign s_axil_wready  = (wr_state == wr_accept);
	assign s_axil_bvalid  = (wr_state == wr_resp);
	assign s_axil_arready = (rd_state == rd_accept);
	assign s_axil_rvalid  = (rd_state == rd_resp);

	assign wr_hs = (wr_state == wr_accept) && s_axil_awvalid && s_axil_wvalid;
	// no strobes at all means no write, any strobe writes the full word
	assign wr_en = wr_hs && (|s_axil_wstrb) && !wr_err;
	assign rd_hs = (rd_state == rd_accept) && s_axil_arvalid;

	// write decode
	always_comb begin
		wr_err = 1'b0;
		wr_dividend = 1'b0;
		wr_divisor = 1'b0;
		wr_start = 1'b0;
		case (s_axil_awaddr)
			reg_dividend: begin
				wr_err = busy;
				wr_dividend = !busy;
			end
			reg_divisor: begin
				wr_err = busy;
				wr_divisor = !busy;
			end
			reg_ctrl: begin
				// start while busy is refused, writing 0 is harmless
				if (s_axil_wdata[ctrl_start_bit]) begin
					wr_err = busy;
					wr_start = !busy;
				end
			end
			// read-only and unmapped
			default: wr_err = 1'b1;
		endcase
	end

	// read decode
	always_comb begin
		rd_err = 1'b0;
		rd_data = '0;
		case (s_axil_araddr)
			reg_dividend: rd_data = dividend;
			reg_divisor:  rd_data = divisor;
			// write-only, reads back zero
			reg_ctrl:     rd_data = '0;
			reg_status: begin
				rd_data[status_busy_bit] = busy;
				rd_data[status_done_bit] = done;
				rd_data[status_zero_bit] = div_zero;
			end
			reg_quot:     rd_data = quotient;
			reg_rem:      rd_data = remainder;
			reg_cycles:   rd_data = cycles;
			default:      rd_err = 1'b1;
		endcase
	end

	// write channel
	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			wr_state <= wr_idle;
			s_axil_bresp <= resp_okay;
			dividend <= '0;
			divisor <= '0;
			start_arm <= 1'b0;
			start <= 1'b0;
		end else begin
			// start one cycle after bvalid rises
			start <= start_arm;
			start_arm <= wr_en && wr_start;
			case (wr_state)
				wr_idle:
					if (s_axil_awvalid && s_axil_wvalid)
						wr_state <= wr_accept;
				wr_accept:
					if (wr_hs) begin
						s_axil_bresp <= wr_err ? resp_slverr : resp_okay;
						wr_state <= wr_resp;
					end
				default:
					// hold the response until taken
					if (s_axil_bready)
						wr_state <= wr_idle;
			endcase
			if (wr_en && wr_dividend)
				dividend <= s_axil_wdata & op_mask;
			if (wr_en && wr_divisor)
				divisor <= s_axil_wdata & op_mask;
		end
	end

	// read channel
	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			rd_state <= rd_idle;
			s_axil_rdata <= '0;
			s_axil_rresp <= resp_okay;
		end else begin
			case (rd_state)
				rd_idle:
					if (s_axil_arvalid)
						rd_state <= rd_accept;
				rd_accept:
					if (rd_hs) begin
						s_axil_rdata <= rd_data;
						s_axil_rresp <= rd_err ? resp_slverr : resp_okay;
						rd_state <= rd_resp;
					end
				default:
					if (s_axil_rready)
						rd_state <= rd_idle;
			endcase
		end
	end

	// responses survive back-pressure unchanged
	a_bvalid_hold: assert property (@(posedge in_clk) disable iff (in_rst)
		s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid && $stable(s_axil_bresp))
		else $error("bvalid or bresp changed before bready");

	a_rvalid_hold: assert property (@(posedge in_clk) disable iff (in_rst)
		s_axil_rvalid && !s_axil_rready |=>
			s_axil_rvalid && $stable(s_axil_rdata) && $stable(s_axil_rresp))
		else $error("rvalid or read data changed before rready");

endmodule

/* hdl/div_ctrl_fsm.sv */
// divider controller, sequences load, check, subtract and finish and catches a zero divisor
module div_ctrl_fsm #(
	parameter int op_bits = 16
) (
	input  logic in_clk,
	input  logic in_rst,
	input  logic start,
	output logic busy,
	output logic done,
	output logic div_zero,
	div_step_if.ctrl step_bus
);
	import div_types_pkg::*;

	div_state_t state, state_next;

	// operands must fit the bus
	if (op_bits < 1 || op_bits > op_max_bits) begin : g_bad_op_bits
		$error("op_bits out of range");
	end

	// datapath controls
	assign step_bus.load = (state == st_load);
	assign step_bus.zero_fix = (state == st_load) && step_bus.is_zero_div;
	assign step_bus.step = (state == st_sub);

	// the last check already has the final result, so done rises there
	assign busy = (state == st_load) || (state == st_sub) ||
		((state == st_check) && step_bus.ge);
	assign done = (state == st_done) || ((state == st_check) && !step_bus.ge);

	always_comb begin
		state_next = state;
		case (state)
			st_idle:
				if (start)
					state_next = st_load;
			// zero divisor skips the loop
			st_load:
				state_next = step_bus.is_zero_div ? st_done : st_check;
			st_check:
				if (step_bus.ge)
					state_next = st_sub;
				else
					state_next = start ? st_load : st_done;
			st_sub:
				state_next = st_check;
			st_done:
				if (start)
					state_next = st_load;
			default:
				state_next = st_idle;
		endcase
	end

	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			state <= st_idle;
			div_zero <= 1'b0;
		end else begin
			state <= state_next;
			// flag lives until the next start
			if (start)
				div_zero <= 1'b0;
			else if (step_bus.zero_fix)
				div_zero <= 1'b1;
		end
	end

	// a step never borrows
	a_step_no_borrow: assert property (@(posedge in_clk) disable iff (in_rst)
		step_bus.step |-> step_bus.ge)
		else $error("step with remainder below divisor");

	a_state_legal: assert property (@(posedge in_clk) disable iff (in_rst)
		state inside {st_idle, st_load, st_check, st_sub, st_done})
		else $error("illegal controller state");

endmodule

/* hdl/div_iter_timer.sv */
// busy-cycle counter of the divider, cleared by start and frozen once busy falls
module div_iter_timer (
	input  logic in_clk,
	input  logic in_rst,
	input  logic start,
	input  logic busy,
	output div_types_pkg::cycles_t cycles
);
	import div_types_pkg::*;

	cycles_t count;

	assign cycles = count;

	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			count <= '0;
		end else if (start) begin
			// the start cycle itself is the first one
			count <= cycles_t'(1);
		end else if (busy && (count != '1)) begin
			// saturate instead of wrapping
			count <= count + cycles_t'(1);
		end
	end

endmodule

/* hdl/div_datapath.sv */
// divider datapath, quotient and remainder registers with a ripple-carry subtractor
module div_datapath #(
	parameter int op_bits = 16
) (
	input  logic in_clk,
	input  logic in_rst,
	input  div_types_pkg::op_t dividend,
	input  div_types_pkg::op_t divisor,
	div_step_if.data step_bus
);
	import div_types_pkg::*;

	// all ones across op_bits
	localparam op_t op_mask = op_t'((64'd1 << op_bits) - 64'd1);

	op_t quot_q, rem_q;

	// remainder + ~divisor + 1
	logic [op_bits-1:0] div_inv;
	logic [op_bits-1:0] diff;
	logic [op_bits:0] carry;

	assign div_inv = ~divisor[op_bits-1:0];
	// carry in completes the two's complement
	assign carry[0] = 1'b1;

	for (genvar i = 0; i < op_bits; i++) begin : g_rca
		// one full adder per bit
		assign diff[i] = rem_q[i] ^ div_inv[i] ^ carry[i];
		assign carry[i+1] = (rem_q[i] & div_inv[i]) | (carry[i] & (rem_q[i] ^ div_inv[i]));
	end

	// no borrow out means remainder >= divisor
	assign step_bus.ge = carry[op_bits];
	assign step_bus.is_zero_div = (divisor[op_bits-1:0] == '0);

	assign step_bus.quotient = quot_q;
	assign step_bus.remainder = rem_q;

	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			quot_q <= '0;
			rem_q <= '0;
		end else if (step_bus.load) begin
			rem_q <= dividend;
			// zero divisor result, remainder keeps the dividend
			quot_q <= step_bus.zero_fix ? op_mask : '0;
		end else if (step_bus.step) begin
			rem_q <= op_t'(diff);
			quot_q <= (quot_q + op_t'(1)) & op_mask;
		end
	end

	a_rem_shrinks: assert property (@(posedge in_clk) disable iff (in_rst)
		step_bus.step |=> rem_q <= $past(rem_q))
		else $error("remainder grew on a step");

endmodule

/* hdl/div_periph_top.sv */
// divider peripheral top level, AXI4-Lite register block wired to controller, timer, datapath
module div_periph_top #(
	parameter int op_bits = 16
) (
	input  logic in_clk,
	input  logic in_rst,

	// AXI4-Lite slave
	input  div_regmap_pkg::axil_addr_t s_axil_awaddr,
	input  logic s_axil_awvalid,
	output logic s_axil_awready,
	input  div_regmap_pkg::axil_data_t s_axil_wdata,
	input  logic [div_regmap_pkg::axil_strb_bits-1:0] s_axil_wstrb,
	input  logic s_axil_wvalid,
	output logic s_axil_wready,
	output div_regmap_pkg::axil_resp_t s_axil_bresp,
	output logic s_axil_bvalid,
	input  logic s_axil_bready,
	input  div_regmap_pkg::axil_addr_t s_axil_araddr,
	input  logic s_axil_arvalid,
	output logic s_axil_arready,
	output div_regmap_pkg::axil_data_t s_axil_rdata,
	output div_regmap_pkg::axil_resp_t s_axil_rresp,
	output logic s_axil_rvalid,
	input  logic s_axil_rready
);
	import div_types_pkg::*;

	// start, busy, done travel as plain wires
	logic start, busy, done, div_zero;
	op_t dividend, divisor;
	cycles_t cycles;

	div_step_if step_bus ();

	div_axil_regs #(.op_bits(op_bits)) u_regs (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.s_axil_awaddr(s_axil_awaddr),
		.s_axil_awvalid(s_axil_awvalid),
		.s_axil_awready(s_axil_awready),
		.s_axil_wdata(s_axil_wdata),
		.s_axil_wstrb(s_axil_wstrb),
		.s_axil_wvalid(s_axil_wvalid),
		.s_axil_wready(s_axil_wready),
		.s_axil_bresp(s_axil_bresp),
		.s_axil_bvalid(s_axil_bvalid),
		.s_axil_bready(s_axil_bready),
		.s_axil_araddr(s_axil_araddr),
		.s_axil_arvalid(s_axil_arvalid),
		.s_axil_arready(s_axil_arready),
		.s_axil_rdata(s_axil_rdata),
		.s_axil_rresp(s_axil_rresp),
		.s_axil_rvalid(s_axil_rvalid),
		.s_axil_rready(s_axil_rready),
		.start(start),
		.busy(busy),
		.done(done),
		.div_zero(div_zero),
		// results come off the step bus
		.quotient(step_bus.quotient),
		.remainder(step_bus.remainder),
		.cycles(cycles),
		.dividend(dividend),
		.divisor(divisor)
	);

	div_ctrl_fsm #(.op_bits(op_bits)) u_ctrl (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.start(start),
		.busy(busy),
		.done(done),
		.div_zero(div_zero),
		.step_bus(step_bus.ctrl)
	);

	div_iter_timer u_timer (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.start(start),
		.busy(busy),
		.cycles(cycles)
	);

	div_datapath #(.op_bits(op_bits)) u_datapath (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.dividend(dividend),
		.divisor(divisor),
		.step_bus(step_bus.data)
	);

endmodule

/* dv/div_tb.sv */
// directed testbench for the divider peripheral, drives AXI4-Lite and checks against integer division
module div_tb;
	import div_regmap_pkg::*;

	localparam int op_bits = 16;
	localparam int n_rand = 20;
	localparam int bp_hold = 5;
	localparam int unsigned op_ones = (32'd1 << op_bits) - 32'd1;

	// long division for the start-while-busy test
	localparam int unsigned busy_a = 60000;
	localparam int unsigned busy_b = 3;
	// operands for the back-pressure test
	localparam int unsigned bp_a = 1000;
	localparam int unsigned bp_b = 7;
	localparam int unsigned zero_a = 32'h1234;

	logic in_clk = 1'b0;
	logic in_rst;
	axil_addr_t s_axil_awaddr;
	logic s_axil_awvalid;
	logic s_axil_awready;
	axil_data_t s_axil_wdata;
	logic [axil_strb_bits-1:0] s_axil_wstrb;
	logic s_axil_wvalid;
	logic s_axil_wready;
	axil_resp_t s_axil_bresp;
	logic s_axil_bvalid;
	logic s_axil_bready;
	axil_addr_t s_axil_araddr;
	logic s_axil_arvalid;
	logic s_axil_arready;
	axil_data_t s_axil_rdata;
	axil_resp_t s_axil_rresp;
	logic s_axil_rvalid;
	logic s_axil_rready;

	int unsigned error_count = 0;
	int unsigned check_count = 0;
	int unsigned cycle_count = 0;
	// zero until the test lengths are known
	int unsigned cycle_limit = 0;

	int unsigned dir_dividend [4] = '{100, 7, 65535, 5};
	int unsigned dir_divisor [4] = '{7, 100, 1, 5};
	int unsigned rand_dividend [n_rand];
	int unsigned rand_divisor [n_rand];

	div_periph_top #(.op_bits(op_bits)) dut (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.s_axil_awaddr(s_axil_awaddr),
		.s_axil_awvalid(s_axil_awvalid),
		.s_axil_awready(s_axil_awready),
		.s_axil_wdata(s_axil_wdata),
		.s_axil_wstrb(s_axil_wstrb),
		.s_axil_wvalid(s_axil_wvalid),
		.s_axil_wready(s_axil_wready),
		.s_axil_bresp(s_axil_bresp),
		.s_axil_bvalid(s_axil_bvalid),
		.s_axil_bready(s_axil_bready),
		.s_axil_araddr(s_axil_araddr),
		.s_axil_arvalid(s_axil_arvalid),
		.s_axil_arready(s_axil_arready),
		.s_axil_rdata(s_axil_rdata),
		.s_axil_rresp(s_axil_rresp),
		.s_axil_rvalid(s_axil_rvalid),
		.s_axil_rready(s_axil_rready)
	);

	always #2 in_clk = ~in_clk;

	// watchdog
	always @(posedge in_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
			$display("run timed out after %0d cycles, the DUT never finished", cycle_count);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
		check_count++;
		if (got !== expected) begin
			error_count++;
			$display("ERROR: %s got 0x%08h expected 0x%08h (cycle %0d)",
				name, got, expected, cycle_count);
		end
	endtask

	// busy cycles of one division, 2 for a zero divisor
	function automatic int unsigned div_len(input int unsigned a, input int unsigned b);
		if (b == 0)
			return 2;
		return 2 * (a / b) + 2;
	endfunction

	// hold > 0 keeps bready low that many cycles after bvalid
	task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
			output axil_resp_t resp, input int hold = 0);
		axil_resp_t first_resp;
		@(posedge in_clk);
		s_axil_awaddr <= addr;
		s_axil_awvalid <= 1'b1;
		s_axil_wdata <= data;
		s_axil_wstrb <= '1;
		s_axil_wvalid <= 1'b1;
		s_axil_bready <= (hold == 0);
		@(negedge in_clk);
		while (!s_axil_awready)
			@(negedge in_clk);
		// aw and w accepted together
		check("s_axil_wready", 32'(s_axil_wready), 32'd1);
		@(posedge in_clk);
		s_axil_awvalid <= 1'b0;
		s_axil_wvalid <= 1'b0;
		@(negedge in_clk);
		check("s_axil_bvalid", 32'(s_axil_bvalid), 32'd1);
		while (!s_axil_bvalid)
			@(negedge in_clk);
		first_resp = s_axil_bresp;
		repeat (hold) begin
			@(negedge in_clk);
			check("s_axil_bvalid", 32'(s_axil_bvalid), 32'd1);
			check("s_axil_bresp", 32'(s_axil_bresp), 32'(first_resp));
		end
		if (hold > 0) begin
			@(posedge in_clk);
			s_axil_bready <= 1'b1;
			@(negedge in_clk);
		end
		resp = s_axil_bresp;
		// handshake on this edge
		@(posedge in_clk);
		s_axil_bready <= 1'b0;
	endtask

	// hold > 0 keeps rready low that many cycles after rvalid
	task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
			output axil_resp_t resp, input int hold = 0);
		axil_data_t first_data;
		axil_resp_t first_resp;
		@(posedge in_clk);
		s_axil_araddr <= addr;
		s_axil_arvalid <= 1'b1;
		s_axil_rready <= (hold == 0);
		@(negedge in_clk);
		while (!s_axil_arready)
			@(negedge in_clk);
		@(posedge in_clk);
		s_axil_arvalid <= 1'b0;
		// rvalid one cycle after the ar handshake
		@(negedge in_clk);
		check("s_axil_rvalid", 32'(s_axil_rvalid), 32'd1);
		while (!s_axil_rvalid)
			@(negedge in_clk);
		first_data = s_axil_rdata;
		first_resp = s_axil_rresp;
		repeat (hold) begin
			@(negedge in_clk);
			check("s_axil_rvalid", 32'(s_axil_rvalid), 32'd1);
			check("s_axil_rdata", s_axil_rdata, first_data);
			check("s_axil_rresp", 32'(s_axil_rresp), 32'(first_resp));
		end
		if (hold > 0) begin
			@(posedge in_clk);
			s_axil_rready <= 1'b1;
			@(negedge in_clk);
		end
		data = s_axil_rdata;
		resp = s_axil_rresp;
		@(posedge in_clk);
		s_axil_rready <= 1'b0;
	endtask

	task automatic write_expect(input axil_addr_t addr, input axil_data_t data,
			input axil_resp_t exp_resp, input int hold = 0);
		axil_resp_t resp;
		axil_write(addr, data, resp, hold);
		check($sformatf("s_axil_bresp @0x%02h", addr), 32'(resp), 32'(exp_resp));
	endtask

	task automatic read_expect(input string name, input axil_addr_t addr,
			input axil_data_t exp_data, input axil_resp_t exp_resp, input int hold = 0);
		axil_data_t data;
		axil_resp_t resp;
		axil_read(addr, data, resp, hold);
		check(name, data, exp_data);
		check({name, " rresp"}, 32'(resp), 32'(exp_resp));
	endtask

	// poll status until done
	task automatic wait_done(output axil_data_t status);
		axil_resp_t resp;
		status = '0;
		while (!status[status_done_bit])
			axil_read(reg_status, status, resp);
	endtask

	task automatic start_division(input int unsigned a, input int unsigned b, input int hold = 0);
		write_expect(reg_dividend, a, resp_okay, hold);
		write_expect(reg_divisor, b, resp_okay, hold);
		write_expect(reg_ctrl, 32'h1, resp_okay, hold);
	endtask

	// expected values straight from integer division
	task automatic check_result(input int unsigned a, input int unsigned b, input int hold = 0);
		axil_data_t status;
		int unsigned q_exp;
		int unsigned r_exp;
		q_exp = (b == 0) ? op_ones : a / b;
		r_exp = (b == 0) ? a : a % b;
		wait_done(status);
		// done, plus div_zero for a zero divisor
		check("reg_status", status, (b == 0) ? 32'h6 : 32'h2);
		read_expect("reg_quot", reg_quot, q_exp, resp_okay, hold);
		read_expect("reg_rem", reg_rem, r_exp, resp_okay, hold);
		read_expect("reg_cycles", reg_cycles, div_len(a, b), resp_okay, hold);
	endtask

	task automatic test_reset_values();
		@(negedge in_clk);
		check("s_axil_awready", 32'(s_axil_awready), 32'd0);
		check("s_axil_wready", 32'(s_axil_wready), 32'd0);
		check("s_axil_arready", 32'(s_axil_arready), 32'd0);
		check("s_axil_bvalid", 32'(s_axil_bvalid), 32'd0);
		check("s_axil_rvalid", 32'(s_axil_rvalid), 32'd0);
		read_expect("reg_status", reg_status, 32'h0, resp_okay);
		read_expect("reg_quot", reg_quot, 32'h0, resp_okay);
		read_expect("reg_rem", reg_rem, 32'h0, resp_okay);
		read_expect("reg_cycles", reg_cycles, 32'h0, resp_okay);
	endtask

	task automatic test_operand_readback();
		// upper bits dropped at op_bits
		write_expect(reg_dividend, 32'h0001_2345, resp_okay);
		write_expect(reg_divisor, 32'hABCD_EF01, resp_okay);
		read_expect("reg_dividend", reg_dividend, 32'h0000_2345, resp_okay);
		read_expect("reg_divisor", reg_divisor, 32'h0000_EF01, resp_okay);
	endtask

	task automatic test_divisions();
		int i;
		for (i = 0; i < 4; i++) begin
			start_division(dir_dividend[i], dir_divisor[i]);
			check_result(dir_dividend[i], dir_divisor[i]);
		end
		for (i = 0; i < n_rand; i++) begin
			start_division(rand_dividend[i], rand_divisor[i]);
			check_result(rand_dividend[i], rand_divisor[i]);
		end
	endtask

	task automatic test_zero_divisor();
		start_division(zero_a, 0);
		check_result(zero_a, 0);
	endtask

	// runs right after the zero divisor test, so its results are known
	task automatic test_error_responses();
		write_expect(8'h20, 32'hDEAD_BEEF, resp_slverr);
		read_expect("unmapped 0x20", 8'h20, 32'h0, resp_slverr);
		write_expect(reg_quot, 32'h0000_0055, resp_slverr);
		write_expect(reg_status, 32'h0000_0007, resp_slverr);
		read_expect("reg_quot", reg_quot, op_ones, resp_okay);
		read_expect("reg_rem", reg_rem, zero_a, resp_okay);
		read_expect("reg_dividend", reg_dividend, zero_a, resp_okay);
		read_expect("reg_divisor", reg_divisor, 32'h0, resp_okay);
		read_expect("reg_status", reg_status, 32'h6, resp_okay);
	endtask

	task automatic test_start_while_busy();
		start_division(busy_a, busy_b);
		// still thousands of cycles to go
		read_expect("reg_status", reg_status, 32'h1, resp_okay);
		write_expect(reg_ctrl, 32'h1, resp_slverr);
		write_expect(reg_dividend, 32'h1111, resp_slverr);
		write_expect(reg_divisor, 32'h7, resp_slverr);
		read_expect("reg_dividend", reg_dividend, busy_a, resp_okay);
		read_expect("reg_divisor", reg_divisor, busy_b, resp_okay);
		check_result(busy_a, busy_b);
	endtask

	task automatic test_back_pressure();
		start_division(bp_a, bp_b, bp_hold);
		check_result(bp_a, bp_b, bp_hold);
	endtask

	initial begin
		int i;
		int unsigned d;
		int unsigned q;
		int unsigned total_len;
		void'($urandom(62));
		in_rst <= 1'b1;
		s_axil_awaddr <= '0;
		s_axil_awvalid <= 1'b0;
		s_axil_wdata <= '0;
		s_axil_wstrb <= '0;
		s_axil_wvalid <= 1'b0;
		s_axil_bready <= 1'b0;
		s_axil_araddr <= '0;
		s_axil_arvalid <= 1'b0;
		s_axil_rready <= 1'b0;

		// random pairs, quotient at most 20
		for (i = 0; i < n_rand; i++) begin
			d = $urandom_range(3000, 1);
			q = $urandom_range(20, 0);
			rand_divisor[i] = d;
			rand_dividend[i] = q * d + $urandom_range(d - 1, 0);
		end

		total_len = div_len(zero_a, 0) + div_len(busy_a, busy_b) + div_len(bp_a, bp_b);
		for (i = 0; i < 4; i++)
			total_len += div_len(dir_dividend[i], dir_divisor[i]);
		for (i = 0; i < n_rand; i++)
			total_len += div_len(rand_dividend[i], rand_divisor[i]);
		cycle_limit = 20 * total_len + 2000;

		repeat (10) @(posedge in_clk);
		in_rst <= 1'b0;

		test_reset_values();
		test_operand_readback();
		test_divisions();
		test_zero_divisor();
		test_error_responses();
		test_start_while_busy();
		test_back_pressure();

		repeat (4) @(posedge in_clk);
		$display("%0d checks, %0d errors", check_count, error_count);
		if (error_count == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

/* sources.f */
hdl/div_types_pkg.sv
hdl/div_regmap_pkg.sv
hdl/div_step_if.sv
hdl/div_axil_regs.sv
hdl/div_ctrl_fsm.sv
hdl/div_iter_timer.sv
hdl/div_datapath.sv
hdl/div_periph_top.sv
dv/div_tb.sv

/* Makefile */
# Verilator build and run of the divider peripheral testbench

VERILATOR ?= verilator
TOP       ?= div_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_LINE ?= RESULT: PASS

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator, run $(TOP), fail unless the pass line is printed"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_LINE"

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx '$(PASS_LINE)'

clean:
	rm -rf $(BUILD_DIR)
